// ==== design/acoustic_cc_params.svh ====
// Correlator size parameters
`ifndef ACOUSTIC_CC_PARAMS_SVH
`define ACOUSTIC_CC_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Samples held per channel; the number of lags is the same.
`define CC_FRAME_LEN 16

// Width of a frame index or lag, enough to address CC_FRAME_LEN entries.
`define CC_LAG_W 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Signed sample width for both channels.
`define CC_SAMPLE_W 16

// A product is 32 bits and a lag sums 16 of them, so 36 bits would do.
// The extra headroom keeps the total clear of any wrap.
`define CC_ACC_W 40

`endif

// ==== design/acoustic_cc_pkg.sv ====
// Correlator shared types
`default_nettype none

`include "acoustic_cc_params.svh"

package acoustic_cc_pkg;

    // One signed audio sample from either channel.
    typedef logic signed [`CC_SAMPLE_W-1:0] sample_t;

    // Signed sum of products for one lag.
    typedef logic signed [`CC_ACC_W-1:0] acc_t;

    // Lag number or position inside a frame.
    typedef logic [`CC_LAG_W-1:0] lag_t;

    // Sequencer states. Drain waits for the last products to leave the pipeline.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } cc_state_t;

endpackage

`default_nettype wire

// ==== design/frame_port_if.sv ====
// Frame read port bundle
`default_nettype none

interface frame_port_if;
    import acoustic_cc_pkg::*;

    // Held high by the sequencer while it reads, which freezes the frame.
    logic send_frame;

    // Address relative to the oldest stored sample.
    lag_t rd_addr;

    // Read data, valid one cycle after rd_addr.
    sample_t rd_data;

    // The buffer has seen a whole frame since reset.
    logic frame_full;

    modport reader (
        output send_frame,
        output rd_addr,
        input  rd_data,
        input  frame_full
    );

    modport store (
        input  send_frame,
        input  rd_addr,
        output rd_data,
        output frame_full
    );

endinterface

`default_nettype wire

// ==== design/ring_buffer.sv ====
// Channel sample ring buffer
`default_nettype none

`include "acoustic_cc_params.svh"

module ring_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  acoustic_cc_pkg::sample_t sample_in,
    input  logic                     sample_valid,
    output logic                     ram_overflow,
    frame_port_if.store              port
);
    import acoustic_cc_pkg::*;

    sample_t              mem [`CC_FRAME_LEN];
    lag_t                 wr_ptr;
    logic [`CC_LAG_W:0]   count;
    logic                 write;
    lag_t                 rd_index;

    // Samples arriving during a frame read are lost.
    assign write = sample_valid && !port.send_frame;

    assign port.frame_full = (count == `CC_FRAME_LEN);

    // Once the buffer is full the write pointer sits on the oldest sample,
    // so adding it turns the relative address into an absolute one.
    assign rd_index = wr_ptr + port.rd_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write pointer, fill count, overflow
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr       <= '0;
            count        <= '0;
            ram_overflow <= 1'b0;
        end else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (!port.frame_full) begin
                    count <= count + 1'b1;
                end
            end
            // Sticky until reset.
            if (sample_valid && port.send_frame) begin
                ram_overflow <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and registered read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= sample_in;
        end
        port.rd_data <= mem[rd_index];
    end

endmodule

`default_nettype wire

// ==== design/cc_control.sv ====
// Cross-correlation sequencer
`default_nettype none

`include "acoustic_cc_params.svh"

module cc_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_cc,
    frame_port_if.reader          x_port,
    frame_port_if.reader          y_port,
    output logic                  cc_busy,
    output logic                  mac_clear,
    output logic                  mac_en,
    output logic                  mac_last,
    output acoustic_cc_pkg::lag_t lag_index,
    output logic                  peak_clear,
    output logic                  cc_done
);
    import acoustic_cc_pkg::*;

    localparam lag_t LAST_IDX = lag_t'(`CC_FRAME_LEN - 1);

    cc_state_t state;
    lag_t      lag_k;
    lag_t      idx_n;
    lag_t      lag_d1;
    logic      accept;
    logic      issue;
    logic      issue_first;
    logic      issue_last;
    logic      issue_final;
    logic      final_d1;
    logic      final_d2;

    // A start needs both frames complete; anything else is ignored.
    assign accept = (state == ST_IDLE) && start_cc
                    && x_port.frame_full && y_port.frame_full;
    assign peak_clear = accept;

    assign issue       = (state == ST_RUN);
    assign issue_first = issue && (idx_n == '0);
    assign issue_last  = issue && (idx_n == LAST_IDX);
    assign issue_final = issue_last && (lag_k == LAST_IDX);

    // x is read at n and y at n+k; the 4-bit add wraps the lag circularly.
    assign x_port.rd_addr    = idx_n;
    assign y_port.rd_addr    = idx_n + lag_k;
    assign x_port.send_frame = cc_busy;
    assign y_port.send_frame = cc_busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State and counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            cc_busy <= 1'b0;
            lag_k   <= '0;
            idx_n   <= '0;
            cc_done <= 1'b0;
        end else begin
            cc_done <= final_d2;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_RUN;
                        cc_busy <= 1'b1;
                        lag_k   <= '0;
                        idx_n   <= '0;
                    end
                end
                ST_RUN: begin
                    idx_n <= idx_n + 1'b1;
                    if (idx_n == LAST_IDX) begin
                        lag_k <= lag_k + 1'b1;
                        if (lag_k == LAST_IDX) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    // The last lag total is in the peak detector this cycle.
                    if (final_d2) begin
                        state   <= ST_IDLE;
                        cc_busy <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Strobes trail the read address by the one cycle of RAM latency.
    always_ff @(posedge clk) begin
        if (reset) begin
            mac_en    <= 1'b0;
            mac_clear <= 1'b0;
            mac_last  <= 1'b0;
            final_d1  <= 1'b0;
            final_d2  <= 1'b0;
        end else begin
            mac_en    <= issue;
            mac_clear <= issue_first;
            mac_last  <= issue_last;
            final_d1  <= issue_final;
            final_d2  <= final_d1;
        end
    end

    // Lag number follows the product through read and MAC stages.
    always_ff @(posedge clk) begin
        lag_d1    <= lag_k;
        lag_index <= lag_d1;
    end

endmodule

`default_nettype wire

// ==== design/lag_mac.sv ====
// Per-lag multiply-accumulate
`default_nettype none

`include "acoustic_cc_params.svh"

module lag_mac (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mac_clear,
    input  logic                     mac_en,
    input  logic                     mac_last,
    input  acoustic_cc_pkg::sample_t x_data,
    input  acoustic_cc_pkg::sample_t y_data,
    output logic                     lag_valid,
    output acoustic_cc_pkg::acc_t    lag_total
);
    import acoustic_cc_pkg::*;

    logic signed [2*`CC_SAMPLE_W-1:0] product;
    acc_t                             product_ext;
    acc_t                             acc;
    acc_t                             acc_next;

    assign product     = x_data * y_data;
    assign product_ext = acc_t'(product);

    // The first product of a lag replaces whatever the last lag left behind.
    assign acc_next = mac_clear ? product_ext : acc + product_ext;

    always_ff @(posedge clk) begin
        if (mac_en) begin
            acc <= acc_next;
        end
        if (mac_en && mac_last) begin
            lag_total <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lag_valid <= 1'b0;
        end else begin
            lag_valid <= mac_en && mac_last;
        end
    end

endmodule

`default_nettype wire

// ==== design/peak_detector.sv ====
// Correlation peak search
`default_nettype none

module peak_detector (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  peak_clear,
    input  logic                  lag_valid,
    input  acoustic_cc_pkg::acc_t lag_total,
    input  acoustic_cc_pkg::lag_t lag_index,
    input  logic                  cc_done,
    output acoustic_cc_pkg::lag_t index_out,
    output acoustic_cc_pkg::acc_t peak_value
);
    import acoustic_cc_pkg::*;

    acc_t max_value;
    lag_t max_index;
    acc_t held_value;
    lag_t held_index;
    logic have_max;

    always_ff @(posedge clk) begin
        if (reset || peak_clear) begin
            have_max <= 1'b0;
        end else if (lag_valid) begin
            have_max <= 1'b1;
        end
    end

    // Strictly greater, so on a tie the earliest (lowest) lag stays.
    always_ff @(posedge clk) begin
        if (lag_valid && (!have_max || lag_total > max_value)) begin
            max_value <= lag_total;
            max_index <= lag_index;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held_value <= '0;
            held_index <= '0;
        end else if (cc_done) begin
            held_value <= max_value;
            held_index <= max_index;
        end
    end

    // The new result shows on the done cycle itself and is held afterwards.
    assign index_out  = cc_done ? max_index : held_index;
    assign peak_value = cc_done ? max_value : held_value;

endmodule

`default_nettype wire

// ==== design/cc_block.sv ====
// Time-delay estimator top level
`default_nettype none

module cc_block (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_cc,
    input  logic                     sample_valid,
    input  acoustic_cc_pkg::sample_t x_sample,
    input  acoustic_cc_pkg::sample_t y_sample,
    output logic                     cc_busy,
    output logic                     cc_done,
    output logic                     ram_overflow,
    output acoustic_cc_pkg::lag_t    index_out,
    output acoustic_cc_pkg::acc_t    peak_value
);
    import acoustic_cc_pkg::*;

    frame_port_if x_port ();
    frame_port_if y_port ();

    logic x_overflow;
    logic y_overflow;
    logic mac_clear;
    logic mac_en;
    logic mac_last;
    logic peak_clear;
    logic lag_valid;
    acc_t lag_total;
    lag_t lag_index;

    assign ram_overflow = x_overflow | y_overflow;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Channel storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ring_buffer x_buffer (
        .clk          (clk),
        .reset        (reset),
        .sample_in    (x_sample),
        .sample_valid (sample_valid),
        .ram_overflow (x_overflow),
        .port         (x_port.store)
    );

    ring_buffer y_buffer (
        .clk          (clk),
        .reset        (reset),
        .sample_in    (y_sample),
        .sample_valid (sample_valid),
        .ram_overflow (y_overflow),
        .port         (y_port.store)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Correlation datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cc_control control (
        .clk        (clk),
        .reset      (reset),
        .start_cc   (start_cc),
        .x_port     (x_port.reader),
        .y_port     (y_port.reader),
        .cc_busy    (cc_busy),
        .mac_clear  (mac_clear),
        .mac_en     (mac_en),
        .mac_last   (mac_last),
        .lag_index  (lag_index),
        .peak_clear (peak_clear),
        .cc_done    (cc_done)
    );

    lag_mac mac (
        .clk       (clk),
        .reset     (reset),
        .mac_clear (mac_clear),
        .mac_en    (mac_en),
        .mac_last  (mac_last),
        .x_data    (x_port.rd_data),
        .y_data    (y_port.rd_data),
        .lag_valid (lag_valid),
        .lag_total (lag_total)
    );

    peak_detector peak (
        .clk        (clk),
        .reset      (reset),
        .peak_clear (peak_clear),
        .lag_valid  (lag_valid),
        .lag_total  (lag_total),
        .lag_index  (lag_index),
        .cc_done    (cc_done),
        .index_out  (index_out),
        .peak_value (peak_value)
    );

endmodule

`default_nettype wire

// ==== testbench/full_pipeline_tb.sv ====
// Correlator pipeline testbench
`default_nettype none

`include "acoustic_cc_params.svh"

module full_pipeline_tb;
    import acoustic_cc_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 400;
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES;
    localparam int DONE_WAIT   = 400;
    localparam int N           = `CC_FRAME_LEN;

    logic    clk;
    logic    reset;
    logic    start_cc;
    logic    sample_valid;
    sample_t x_sample;
    sample_t y_sample;
    logic    cc_busy;
    logic    cc_done;
    logic    ram_overflow;
    lag_t    index_out;
    acc_t    peak_value;

    integer  seed;
    int      cycle_count;
    int      error_count;
    int      tests_passed;
    int      tests_failed;
    sample_t x_frame [N];
    sample_t y_frame [N];
    lag_t    exp_index;
    longint  exp_peak;

    cc_block uut (
        .clk          (clk),
        .reset        (reset),
        .start_cc     (start_cc),
        .sample_valid (sample_valid),
        .x_sample     (x_sample),
        .y_sample     (y_sample),
        .cc_busy      (cc_busy),
        .cc_done      (cc_done),
        .ram_overflow (ram_overflow),
        .index_out    (index_out),
        .peak_value   (peak_value)
    );

    always #50 clk = ~clk;

    // Watchdog over the whole run.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped: still going after %0d clock cycles.", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // r[k] = sum of x[n] * y[(n+k) mod N]; the first (lowest) lag keeps a tie.
    function automatic void correlate_frames();
        longint sum;
        exp_index = '0;
        exp_peak  = 0;
        for (int k = 0; k < N; k++) begin
            sum = 0;
            for (int n = 0; n < N; n++) begin
                sum += longint'(x_frame[n]) * longint'(y_frame[(n + k) % N]);
            end
            if (k == 0 || sum > exp_peak) begin
                exp_peak  = sum;
                exp_index = lag_t'(k);
            end
        end
    endfunction

    // A negative shift gives independent y samples, otherwise y is x delayed.
    task automatic fill_random(input int shift);
        for (int m = 0; m < N; m++) begin
            x_frame[m] = sample_t'($random(seed));
            y_frame[m] = sample_t'($random(seed));
        end
        if (shift >= 0) begin
            for (int m = 0; m < N; m++) begin
                y_frame[m] = x_frame[(m - shift + N) % N];
            end
        end
    endtask

    task automatic load_frames(input int count);
        for (int m = 0; m < count; m++) begin
            @(negedge clk);
            sample_valid = 1'b1;
            x_sample     = x_frame[m];
            y_sample     = y_frame[m];
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start_cc = 1'b1;
        @(negedge clk);
        start_cc = 1'b0;
    endtask

    // Runs one correlation, optionally strobing samples while busy.
    task automatic run_and_check(input int busy_writes);
        int waited;
        waited = 0;
        pulse_start();
        assert (cc_busy) else begin
            $display("Fail at %0t: cc_busy did not rise after start_cc", $time);
            error_count++;
        end
        for (int i = 0; i < busy_writes; i++) begin
            sample_valid = 1'b1;
            x_sample     = sample_t'($random(seed));
            y_sample     = sample_t'($random(seed));
            @(negedge clk);
        end
        sample_valid = 1'b0;
        while (!cc_done && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cc_done) begin
            $display("Timeout: cc_done did not arrive within %0d cycles.", DONE_WAIT);
            error_count++;
        end else begin
            assert (index_out == exp_index) else begin
                $display("Fail at %0t: index_out %0d, expected %0d",
                         $time, index_out, exp_index);
                error_count++;
            end
            assert (peak_value == acc_t'(exp_peak)) else begin
                $display("Fail at %0t: peak_value %0d, expected %0d",
                         $time, peak_value, exp_peak);
                error_count++;
            end
            assert (!cc_busy && uut.control.state == ST_IDLE) else begin
                $display("Fail at %0t: sequencer still busy at cc_done", $time);
                error_count++;
            end
            // Done is a single-cycle pulse.
            @(negedge clk);
            assert (!cc_done) else begin
                $display("Fail at %0t: cc_done high for more than one cycle", $time);
                error_count++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int mark;
        seed         = 32'h3628fae6;
        clk          = 1'b0;
        reset        = 1'b1;
        start_cc     = 1'b0;
        sample_valid = 1'b0;
        x_sample     = '0;
        y_sample     = '0;
        cycle_count  = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        mark = error_count;
        assert (!cc_busy && !cc_done && !ram_overflow && index_out == '0
                && peak_value == '0) else begin
            $display("Fail at %0t: outputs not at their reset values", $time);
            error_count++;
        end
        report_test("reset values", mark);

        // Only 10 samples written, so the frames are not full yet.
        mark = error_count;
        fill_random(-1);
        load_frames(10);
        pulse_start();
        repeat (300) begin
            @(negedge clk);
            assert (!cc_busy && !cc_done) else begin
                $display("Fail at %0t: start accepted with partial frames", $time);
                error_count++;
            end
        end
        report_test("early start", mark);

        mark = error_count;
        fill_random(5);
        load_frames(N);
        correlate_frames();
        run_and_check(0);
        assert (index_out == lag_t'(5)) else begin
            $display("Fail at %0t: index_out %0d, expected 5", $time, index_out);
            error_count++;
        end
        report_test("shifted copy", mark);

        mark = error_count;
        repeat (3) begin
            fill_random(-1);
            load_frames(N);
            correlate_frames();
            run_and_check(0);
        end
        report_test("random frames", mark);

        // The second run reuses the frame held during the first.
        mark = error_count;
        fill_random(-1);
        load_frames(N);
        correlate_frames();
        // Writes into full but idle buffers must not raise the flag.
        assert (!ram_overflow) else begin
            $display("Fail at %0t: ram_overflow set without a write during a run", $time);
            error_count++;
        end
        run_and_check(8);
        assert (ram_overflow) else begin
            $display("Fail at %0t: ram_overflow not set by busy writes", $time);
            error_count++;
        end
        run_and_check(0);
        report_test("overflow", mark);

        mark = error_count;
        for (int m = 0; m < N; m++) begin
            x_frame[m] = sample_t'(1200);
            y_frame[m] = sample_t'(1200);
        end
        load_frames(N);
        correlate_frames();
        run_and_check(0);
        assert (index_out == '0) else begin
            $display("Fail at %0t: index_out %0d on a tie, expected 0", $time, index_out);
            error_count++;
        end
        report_test("tie", mark);

        $display("Tests passed: %0d, failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== acoustic_cc.f ====
+incdir+design
design/acoustic_cc_pkg.sv
design/frame_port_if.sv
design/ring_buffer.sv
design/cc_control.sv
design/lag_mac.sv
design/peak_detector.sv
design/cc_block.sv
testbench/full_pipeline_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = full_pipeline_tb
FILELIST  = acoustic_cc.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Result: failure reported in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Result: run ended without a verdict"; exit 1; \
	fi
	@echo "Result: ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
